// ==== imu_burst_sequencer.sv ====
/* IMU transfer sequencer */
`timescale 1ns/1ps
`include "imu_i2c_consts.svh"
`default_nettype none

module imu_burst_sequencer import imu_i2c_pkg::*; (
	input  wire             i2c_clk,
	input  wire             i_rst_n,
	input  wire             i_xfer_valid,
	input  wire xfer_req_t  i_xfer_req,
	output logic            o_xfer_ready,
	input  wire             i_auto_en,
	input  wire             i_drdy,
	output logic            o_done,
	output logic            o_done_nack,
	output logic [7:0]      o_rd_byte,
	output imu_sample_t     o_live,
	output logic            o_live_update,
	output logic            o_bus_valid,
	output bus_cmd_t        o_bus_cmd,
	input  wire             i_bus_ready,
	input  wire             i_bus_done,
	input  wire [7:0]       i_rx_byte,
	input  wire             i_rx_ack
);

	localparam int         WORDS     = `IMU_BURST_BYTES / 2;
	localparam logic [3:0] LAST_BYTE = 4'(`IMU_BURST_BYTES - 1);

	typedef enum logic [3:0] {
		S_IDLE, S_START, S_ADDR_W, S_REG, S_DATA, S_RSTART, S_ADDR_R, S_READ, S_STOP
	} seq_state_e;

	seq_state_e                      state;
	logic                            wait_q;     // byte op running in the engine
	logic                            is_burst;
	logic                            nack_q;
	logic [3:0]                      byte_cnt;
	xfer_req_t                       req_q;
	logic [8*`IMU_BURST_BYTES-1:0]   burst_sh;
	logic                            drdy_s1;
	logic                            drdy_s2;
	logic                            drdy_d;
	logic                            drdy_rise;
	logic                            step_done;
	logic                            ack_step;

	assign drdy_rise    = drdy_s2 && !drdy_d;
	assign step_done    = wait_q && i_bus_done;
	assign o_xfer_ready = (state == S_IDLE);
	assign o_bus_valid  = (state != S_IDLE) && !wait_q;
	assign o_done_nack  = nack_q;
	// steps where the slave has to acknowledge
	assign ack_step = (state == S_ADDR_W) || (state == S_REG) || (state == S_DATA) ||
		(state == S_ADDR_R);

	always_comb begin
		o_bus_cmd.op      = BUS_STOP;
		o_bus_cmd.tx_byte = 8'h00;
		case (state)
			S_START, S_RSTART: o_bus_cmd.op = BUS_START;
			S_ADDR_W: begin
				o_bus_cmd.op      = BUS_WRITE;
				o_bus_cmd.tx_byte = {req_q.dev_addr, 1'b0};
			end
			S_REG: begin
				o_bus_cmd.op      = BUS_WRITE;
				o_bus_cmd.tx_byte = req_q.reg_addr;
			end
			S_DATA: begin
				o_bus_cmd.op      = BUS_WRITE;
				o_bus_cmd.tx_byte = req_q.wdata;
			end
			S_ADDR_R: begin
				o_bus_cmd.op      = BUS_WRITE;
				o_bus_cmd.tx_byte = {req_q.dev_addr, 1'b1};
			end
			S_READ: begin
				if (is_burst && byte_cnt != LAST_BYTE)
					o_bus_cmd.op = BUS_READ_ACK;
				else
					o_bus_cmd.op = BUS_READ_NACK;  // last byte
			end
			default: ;
		endcase
	end

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state         <= S_IDLE;
			wait_q        <= 1'b0;
			is_burst      <= 1'b0;
			nack_q        <= 1'b0;
			byte_cnt      <= 4'd0;
			o_done        <= 1'b0;
			o_live_update <= 1'b0;
			drdy_s1       <= 1'b0;
			drdy_s2       <= 1'b0;
			drdy_d        <= 1'b0;
		end else begin
			o_done        <= 1'b0;
			o_live_update <= 1'b0;
			drdy_s1       <= i_drdy;
			drdy_s2       <= drdy_s1;
			drdy_d        <= drdy_s2;
			if (o_bus_valid && i_bus_ready)
				wait_q <= 1'b1;
			if (state == S_IDLE) begin
				byte_cnt <= 4'd0;
				nack_q   <= 1'b0;
				if (i_xfer_valid) begin  // host request wins
					state    <= S_START;
					is_burst <= 1'b0;
				end else if (i_auto_en && drdy_rise) begin
					state    <= S_START;
					is_burst <= 1'b1;
				end
			end else if (step_done) begin
				wait_q <= 1'b0;
				if (ack_step && !i_rx_ack) begin
					nack_q <= 1'b1;
					state  <= S_STOP;  // give up, release the bus
				end else begin
					case (state)
						S_START:  state <= S_ADDR_W;
						S_ADDR_W: state <= S_REG;
						S_REG: begin
							if (req_q.kind == XFER_WRITE)
								state <= S_DATA;
							else
								state <= S_RSTART;
						end
						S_DATA:   state <= S_STOP;
						S_RSTART: state <= S_ADDR_R;
						S_ADDR_R: state <= S_READ;
						S_READ: begin
							byte_cnt <= byte_cnt + 4'd1;
							if (!is_burst || byte_cnt == LAST_BYTE)
								state <= S_STOP;
						end
						S_STOP: begin
							state <= S_IDLE;
							if (!is_burst)
								o_done <= 1'b1;
							else if (!nack_q)
								o_live_update <= 1'b1;
						end
						default: state <= S_IDLE;
					endcase
				end
			end
		end
	end

	always_ff @(posedge i2c_clk) begin
		if (state == S_IDLE) begin
			if (i_xfer_valid)
				req_q <= i_xfer_req;
			else
				req_q <= '{kind: XFER_READ, dev_addr: `IMU_DEV_ADDR,
					reg_addr: `IMU_REG_OUT_TEMP_L, wdata: 8'h00};
		end
		if (state == S_READ && step_done) begin
			o_rd_byte <= i_rx_byte;
			burst_sh  <= {i_rx_byte, burst_sh[8*`IMU_BURST_BYTES-1:8]};  // low byte first
		end
		// word 0 of the shift register is temp, the top field of the struct
		if (state == S_STOP && step_done && is_burst && !nack_q) begin
			for (int i = 0; i < WORDS; i++)
				o_live[16*(WORDS-1-i) +: 16] <= burst_sh[16*i +: 16];
		end
	end

	assert property (@(posedge i2c_clk) disable iff (!i_rst_n)
		byte_cnt <= 4'(`IMU_BURST_BYTES));

endmodule

`default_nettype wire

// ==== imu_cfg_regs.sv ====
/* IMU command and status registers */
`timescale 1ns/1ps
`default_nettype none

module imu_cfg_regs import imu_i2c_pkg::*; (
	input  wire              i2c_clk,
	input  wire              i_rst_n,
	input  wire              i_cmd_valid,
	input  wire host_cmd_t   i_cmd,
	output logic             o_cmd_ready,
	output logic             o_xfer_valid,
	output xfer_req_t        o_xfer_req,
	input  wire              i_xfer_ready,
	input  wire              i_done,
	input  wire              i_done_nack,
	input  wire [7:0]        i_rd_byte,
	input  wire imu_sample_t i_live,
	input  wire              i_live_update,
	input  wire              i_latch_trigger,
	output logic             o_auto_en,
	output imu_sample_t      o_sample,
	output imu_status_t      o_status
);

	logic       busy;
	logic       finish;
	logic       nack;
	logic       auto_en;
	logic [7:0] rd_data;
	logic       accept;
	logic       load_sample;

	assign o_cmd_ready = !busy;
	assign accept      = i_cmd_valid && o_cmd_ready;
	assign o_auto_en   = auto_en;
	assign o_status    = '{busy: busy, finish: finish, nack: nack, auto_en: auto_en,
		rd_data: rd_data};

	// auto mode waits for the trigger, otherwise follow every burst
	assign load_sample = auto_en ? i_latch_trigger : i_live_update;

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			busy         <= 1'b0;
			finish       <= 1'b0;
			nack         <= 1'b0;
			auto_en      <= 1'b0;
			rd_data      <= 8'h00;
			o_xfer_valid <= 1'b0;
		end else begin
			if (o_xfer_valid && i_xfer_ready)
				o_xfer_valid <= 1'b0;
			if (accept) begin
				finish <= 1'b0;
				nack   <= 1'b0;
				case (i_cmd.op)
					OP_AUTO_ON: begin
						auto_en <= 1'b1;
						finish  <= 1'b1;  // done at once
					end
					OP_AUTO_OFF: begin
						auto_en <= 1'b0;
						finish  <= 1'b1;
					end
					default: begin
						busy         <= 1'b1;  // bus transfer
						o_xfer_valid <= 1'b1;
					end
				endcase
			end else if (i_done) begin
				busy   <= 1'b0;
				finish <= 1'b1;
				nack   <= i_done_nack;
				if (o_xfer_req.kind == XFER_READ && !i_done_nack)
					rd_data <= i_rd_byte;
			end
		end
	end

	always_ff @(posedge i2c_clk) begin
		if (accept) begin
			if (i_cmd.op == OP_READ)
				o_xfer_req.kind <= XFER_READ;
			else
				o_xfer_req.kind <= XFER_WRITE;
			o_xfer_req.dev_addr <= i_cmd.dev_addr;
			o_xfer_req.reg_addr <= i_cmd.reg_addr;
			o_xfer_req.wdata    <= i_cmd.wdata;
		end
	end

	// output latch
	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_sample <= '0;
		else if (load_sample)
			o_sample <= i_live;
	end

	// request held until the sequencer takes it
	assert property (@(posedge i2c_clk) disable iff (!i_rst_n)
		(o_xfer_valid && !i_xfer_ready) |=> (o_xfer_valid && $stable(o_xfer_req)));

endmodule

`default_nettype wire

// ==== imu_i2c_bit_engine.sv ====
/* I2C byte level bit engine */
`timescale 1ns/1ps
`include "imu_i2c_consts.svh"
`default_nettype none

module imu_i2c_bit_engine import imu_i2c_pkg::*; (
	input  wire            i2c_clk,
	input  wire            i_rst_n,
	input  wire            i_bus_valid,
	input  wire bus_cmd_t  i_bus_cmd,
	output logic           o_bus_ready,
	output logic           o_bus_done,
	output logic [7:0]     o_rx_byte,
	output logic           o_rx_ack,
	input  wire            i_scl,
	input  wire            i_sda,
	output logic           o_scl_oe,
	output logic           o_sda_oe
);

	localparam logic [7:0] Q_LAST = 8'(`IMU_SCL_QUARTER - 1);

	logic       busy;
	bus_op_e    cur_op;
	logic [1:0] phase;    // 0 low, 1 high, 2 high, 3 low
	logic [3:0] bit_idx;
	logic [7:0] q_cnt;
	logic [7:0] tx_sh;
	logic       quarter_end;
	logic       last_bit;
	logic       stretch;

	// pull-low enables {scl, sda} for one quarter of a bit
	function automatic logic [1:0] line_drive(bus_op_e op, logic [3:0] bidx,
			logic [1:0] ph, logic txb);
		logic scl_low;
		logic sda_low;
		scl_low = (ph == 2'd0) || (ph == 2'd3);
		case (op)
			BUS_START: sda_low = ph[1];  // falls while SCL is high
			BUS_STOP: begin
				sda_low = !ph[1];  // rises while SCL is high
				if (ph == 2'd3)
					scl_low = 1'b0;  // bus left idle
			end
			BUS_WRITE:    sda_low = (bidx < 4'd8) ? !txb : 1'b0;
			BUS_READ_ACK: sda_low = (bidx == 4'd8);
			default:      sda_low = 1'b0;  // NACK read
		endcase
		return {scl_low, sda_low};
	endfunction

	assign o_bus_ready = !busy;
	assign quarter_end = (q_cnt == Q_LAST);
	assign stretch     = (phase == 2'd1) && !i_scl;  // slave holds SCL low
	assign last_bit    = (cur_op == BUS_START || cur_op == BUS_STOP) ?
		(bit_idx == 4'd0) : (bit_idx == 4'd8);

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			busy       <= 1'b0;
			cur_op     <= BUS_STOP;
			phase      <= 2'd0;
			bit_idx    <= 4'd0;
			q_cnt      <= 8'd0;
			o_scl_oe   <= 1'b0;
			o_sda_oe   <= 1'b0;
			o_bus_done <= 1'b0;
		end else begin
			o_bus_done <= 1'b0;
			if (!busy) begin
				// lines keep their level, SCL stays low between bytes
				if (i_bus_valid) begin
					busy    <= 1'b1;
					cur_op  <= i_bus_cmd.op;
					phase   <= 2'd0;
					bit_idx <= 4'd0;
					q_cnt   <= 8'd0;
					{o_scl_oe, o_sda_oe} <= line_drive(i_bus_cmd.op, 4'd0, 2'd0,
						i_bus_cmd.tx_byte[7]);
				end
			end else if (!stretch) begin
				if (!quarter_end) begin
					q_cnt <= q_cnt + 8'd1;
				end else begin
					q_cnt <= 8'd0;
					if (phase != 2'd3) begin
						phase <= phase + 2'd1;
						{o_scl_oe, o_sda_oe} <= line_drive(cur_op, bit_idx, phase + 2'd1,
							tx_sh[7]);
					end else if (last_bit) begin
						busy       <= 1'b0;
						o_bus_done <= 1'b1;
					end else begin
						phase   <= 2'd0;
						bit_idx <= bit_idx + 4'd1;
						// tx_sh shifts on this edge, so take the next bit
						{o_scl_oe, o_sda_oe} <= line_drive(cur_op, bit_idx + 4'd1, 2'd0,
							tx_sh[6]);
					end
				end
			end
		end
	end

	// tx shifter and bus sampling
	always_ff @(posedge i2c_clk) begin
		if (!busy && i_bus_valid) begin
			tx_sh <= i_bus_cmd.tx_byte;
		end else if (busy && !stretch && quarter_end) begin
			if (phase == 2'd1) begin  // middle of SCL high
				if (bit_idx < 4'd8)
					o_rx_byte <= {o_rx_byte[6:0], i_sda};
				else
					o_rx_ack <= !i_sda;
			end
			if (phase == 2'd3)
				tx_sh <= {tx_sh[6:0], 1'b0};
		end
	end

	// SDA moves under a released SCL only for START and STOP
	assert property (@(posedge i2c_clk) disable iff (!i_rst_n)
		(!o_scl_oe && !$past(o_scl_oe) && (o_sda_oe != $past(o_sda_oe)))
		|-> (busy && (cur_op == BUS_START || cur_op == BUS_STOP)));

endmodule

`default_nettype wire

// ==== imu_i2c_consts.svh ====
/* IMU I2C constants */
`ifndef IMU_I2C_CONSTS_SVH
`define IMU_I2C_CONSTS_SVH

`default_nettype none

// sensor address with SA0 tied low
`define IMU_DEV_ADDR        7'h6A

// first output register of the burst
`define IMU_REG_OUT_TEMP_L  8'h20

`define IMU_BURST_BYTES     14  // temp, gyro xyz, accel xyz, two bytes each

// i2c_clk cycles per quarter SCL period
`define IMU_SCL_QUARTER     2

`default_nettype wire

`endif

// ==== imu_i2c_pkg.sv ====
/* IMU I2C shared types */
`default_nettype none

package imu_i2c_pkg;

	// host command opcodes
	typedef enum logic [1:0] {
		OP_WRITE,
		OP_READ,
		OP_AUTO_ON,
		OP_AUTO_OFF
	} host_op_e;

	typedef struct packed {
		host_op_e    op;
		logic [6:0]  dev_addr;
		logic [7:0]  reg_addr;
		logic [7:0]  wdata;
	} host_cmd_t;

	typedef enum logic {
		XFER_WRITE,
		XFER_READ
	} xfer_kind_e;

	typedef struct packed {
		xfer_kind_e  kind;
		logic [6:0]  dev_addr;
		logic [7:0]  reg_addr;
		logic [7:0]  wdata;
	} xfer_req_t;

	// byte level operations of the bit engine
	typedef enum logic [2:0] {
		BUS_START,
		BUS_WRITE,
		BUS_READ_ACK,
		BUS_READ_NACK,
		BUS_STOP
	} bus_op_e;

	typedef struct packed {
		bus_op_e     op;
		logic [7:0]  tx_byte;
	} bus_cmd_t;

	typedef struct packed {
		logic signed [15:0] temp;
		logic signed [15:0] gyro_x;
		logic signed [15:0] gyro_y;
		logic signed [15:0] gyro_z;
		logic signed [15:0] acc_x;
		logic signed [15:0] acc_y;
		logic signed [15:0] acc_z;
	} imu_sample_t;

	typedef struct packed {
		logic        busy;
		logic        finish;
		logic        nack;
		logic        auto_en;
		logic [7:0]  rd_data;  // last host read byte
	} imu_status_t;

endpackage

`default_nettype wire

// ==== imu_i2c_top.f ====
+incdir+.
imu_i2c_pkg.sv
imu_cfg_regs.sv
imu_burst_sequencer.sv
imu_i2c_bit_engine.sv
imu_i2c_top.sv
tb_i2c_slave_model.sv
tb_imu_i2c_top.sv

// ==== imu_i2c_top.sv ====
/* IMU I2C master top */
`timescale 1ns/1ps
`default_nettype none

module imu_i2c_top import imu_i2c_pkg::*; (
	input  wire             i2c_clk,
	input  wire             i_rst_n,
	input  wire             i_cmd_valid,
	input  wire host_cmd_t  i_cmd,
	output logic            o_cmd_ready,
	input  wire             i_drdy,           // asynchronous
	input  wire             i_latch_trigger,
	output imu_sample_t     o_sample,
	output imu_status_t     o_status,
	input  wire             i_scl,
	input  wire             i_sda,
	output logic            o_scl_oe,
	output logic            o_sda_oe
);

	// register block to sequencer
	logic        xfer_valid;
	xfer_req_t   xfer_req;
	logic        xfer_ready;
	logic        done;
	logic        done_nack;
	logic [7:0]  rd_byte;
	imu_sample_t live;
	logic        live_update;
	logic        auto_en;

	// sequencer to bit engine
	logic        bus_valid;
	bus_cmd_t    bus_cmd;
	logic        bus_ready;
	logic        bus_done;
	logic [7:0]  rx_byte;
	logic        rx_ack;

	imu_cfg_regs u_cfg_regs (
		.i2c_clk         (i2c_clk),
		.i_rst_n         (i_rst_n),
		.i_cmd_valid     (i_cmd_valid),
		.i_cmd           (i_cmd),
		.o_cmd_ready     (o_cmd_ready),
		.o_xfer_valid    (xfer_valid),
		.o_xfer_req      (xfer_req),
		.i_xfer_ready    (xfer_ready),
		.i_done          (done),
		.i_done_nack     (done_nack),
		.i_rd_byte       (rd_byte),
		.i_live          (live),
		.i_live_update   (live_update),
		.i_latch_trigger (i_latch_trigger),
		.o_auto_en       (auto_en),
		.o_sample        (o_sample),
		.o_status        (o_status)
	);

	imu_burst_sequencer u_sequencer (
		.i2c_clk       (i2c_clk),
		.i_rst_n       (i_rst_n),
		.i_xfer_valid  (xfer_valid),
		.i_xfer_req    (xfer_req),
		.o_xfer_ready  (xfer_ready),
		.i_auto_en     (auto_en),
		.i_drdy        (i_drdy),
		.o_done        (done),
		.o_done_nack   (done_nack),
		.o_rd_byte     (rd_byte),
		.o_live        (live),
		.o_live_update (live_update),
		.o_bus_valid   (bus_valid),
		.o_bus_cmd     (bus_cmd),
		.i_bus_ready   (bus_ready),
		.i_bus_done    (bus_done),
		.i_rx_byte     (rx_byte),
		.i_rx_ack      (rx_ack)
	);

	imu_i2c_bit_engine u_bit_engine (
		.i2c_clk     (i2c_clk),
		.i_rst_n     (i_rst_n),
		.i_bus_valid (bus_valid),
		.i_bus_cmd   (bus_cmd),
		.o_bus_ready (bus_ready),
		.o_bus_done  (bus_done),
		.o_rx_byte   (rx_byte),
		.o_rx_ack    (rx_ack),
		.i_scl       (i_scl),
		.i_sda       (i_sda),
		.o_scl_oe    (o_scl_oe),
		.o_sda_oe    (o_sda_oe)
	);

endmodule

`default_nettype wire

// ==== imu_trace.txt ====
# name op dev reg wdata p0..p13 (preloaded from reg upward) expected
# op: 0 write, 1 read, 2 auto burst, 3 auto off then read, 4 held second command
wr_ok 0 6A 10 5A 00 00 00 00 00 00 00 00 00 00 00 00 00 00 5A
rd_ok 1 6A 0F 00 6B 00 00 00 00 00 00 00 00 00 00 00 00 00 6B
wr_bad_dev 0 55 11 77 33 00 00 00 00 00 00 00 00 00 00 00 00 00 33
rd_bad_dev 1 2C 12 00 44 00 00 00 00 00 00 00 00 00 00 00 00 00 6B
burst 2 6A 20 00 34 12 F0 FF 01 80 FF 7F 9A 00 00 C0 55 AA 00
auto_off_rd 3 6A 40 00 C3 00 00 00 00 00 00 00 00 00 00 00 00 00 C3
held_cmd 4 6A 50 9E 00 00 00 00 00 00 00 00 00 00 00 00 00 00 9E

// ==== run_sim.sh ====
#!/bin/sh
# build and run the IMU I2C testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module tb_imu_i2c_top \
	-f imu_i2c_top.f \
	-Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
rc=$?
cat sim.log
if [ $rc -ne 0 ]; then
	echo "Simulation exited with status $rc"
	exit 1
fi

if grep -q "^All tests passed$" sim.log; then
	exit 0
fi
exit 1

// ==== tb_i2c_slave_model.sv ====
/* IMU I2C slave model */
`timescale 1ns/1ps
`include "imu_i2c_consts.svh"
`default_nettype none

module tb_i2c_slave_model (
	input  wire i_scl_oe,  // master pull-low enables
	input  wire i_sda_oe,
	output wire o_scl,
	output wire o_sda
);

	typedef enum logic [2:0] {SL_IDLE, SL_ADDR, SL_REG, SL_DATA, SL_READ} sl_state_e;

	logic [7:0] mem [0:255];
	logic       sda_oe    = 1'b0;
	logic       scl_q     = 1'b1;
	logic       sda_q     = 1'b1;
	logic       skip_fall = 1'b0;  // SCL fall that closes a start
	logic       rw        = 1'b0;
	logic       m_ack     = 1'b0;
	logic [3:0] bcnt      = 4'd0;
	logic [7:0] sh        = 8'h00;
	logic [7:0] tx        = 8'h00;
	logic [7:0] ptr       = 8'h00;
	sl_state_e  state     = SL_IDLE;

	// wired-AND of both sides
	assign o_scl = !i_scl_oe;
	assign o_sda = !(i_sda_oe || sda_oe);

	initial begin
		for (int i = 0; i < 256; i++)
			mem[i] = 8'(i) ^ 8'h5C;
	end

	always @(o_scl or o_sda) begin
		if (o_scl && scl_q && sda_q && !o_sda) begin  // start or repeated start
			state     = SL_ADDR;
			bcnt      = 4'd0;
			skip_fall = 1'b1;
			sda_oe    = 1'b0;
		end else if (o_scl && scl_q && !sda_q && o_sda) begin  // stop
			state  = SL_IDLE;
			sda_oe = 1'b0;
		end else if (o_scl && !scl_q && state != SL_IDLE) begin
			if (bcnt < 4'd8)
				sh = {sh[6:0], o_sda};
			else
				m_ack = !o_sda;
		end else if (!o_scl && scl_q) begin
			if (skip_fall) begin
				skip_fall = 1'b0;
			end else if (state != SL_IDLE) begin
				if (bcnt < 4'd7) begin
					bcnt = bcnt + 4'd1;
					if (state == SL_READ)
						sda_oe = !tx[3'(7 - bcnt)];
				end else if (bcnt == 4'd7) begin
					bcnt = 4'd8;
					sda_oe = 1'b1;  // ack unless told otherwise
					case (state)
						SL_ADDR: begin
							rw = sh[0];
							if (sh[7:1] != `IMU_DEV_ADDR) begin
								state  = SL_IDLE;
								sda_oe = 1'b0;
							end
						end
						SL_REG: ptr = sh;
						SL_DATA: begin
							mem[ptr] = sh;
							ptr = ptr + 8'd1;
						end
						default: sda_oe = 1'b0;  // master acks a read byte
					endcase
				end else begin
					bcnt = 4'd0;
					sda_oe = 1'b0;
					case (state)
						SL_ADDR: state = rw ? SL_READ : SL_REG;
						SL_REG:  state = SL_DATA;
						SL_READ: if (!m_ack) state = SL_IDLE;
						default: ;
					endcase
					if (state == SL_READ) begin
						tx = mem[ptr];
						ptr = ptr + 8'd1;
						sda_oe = !tx[7];
					end
				end
			end
		end
		scl_q = o_scl;
		sda_q = o_sda;
	end

endmodule

`default_nettype wire

// ==== tb_imu_i2c_top.sv ====
/* IMU I2C master testbench */
`timescale 1ns/1ps
`include "imu_i2c_consts.svh"
`default_nettype none

module tb_imu_i2c_top
	import imu_i2c_pkg::*;
();

	localparam int MAX_TESTS = 32;
	localparam int BIT_NS    = 4 * `IMU_SCL_QUARTER * 40;

	logic        i2c_clk;
	logic        i_rst_n;
	logic        i_cmd_valid;
	host_cmd_t   i_cmd;
	logic        o_cmd_ready;
	logic        i_drdy;
	logic        i_latch_trigger;
	imu_sample_t o_sample;
	imu_status_t o_status;
	wire         scl;
	wire         sda;
	wire         scl_oe;
	wire         sda_oe;

	string       t_name [MAX_TESTS];
	int          t_op   [MAX_TESTS];
	logic [7:0]  t_dev  [MAX_TESTS];
	logic [7:0]  t_reg  [MAX_TESTS];
	logic [7:0]  t_data [MAX_TESTS];
	logic [7:0]  t_exp  [MAX_TESTS];
	logic [7:0]  t_pre  [MAX_TESTS][14];
	int          n_tests = 0;
	int          test_err;
	int          n_fail = 0;

	imu_i2c_top DUT (
		.i2c_clk(i2c_clk), .i_rst_n(i_rst_n), .i_cmd_valid(i_cmd_valid), .i_cmd(i_cmd),
		.o_cmd_ready(o_cmd_ready), .i_drdy(i_drdy), .i_latch_trigger(i_latch_trigger),
		.o_sample(o_sample), .o_status(o_status), .i_scl(scl), .i_sda(sda),
		.o_scl_oe(scl_oe), .o_sda_oe(sda_oe)
	);

	tb_i2c_slave_model u_slave (.i_scl_oe(scl_oe), .i_sda_oe(sda_oe), .o_scl(scl), .o_sda(sda));

	initial begin
		i2c_clk = 1'b0;
		forever #20 i2c_clk = ~i2c_clk;
	end

	// trace length sets the run limit
	initial begin
		wait (n_tests > 0);
		#(n_tests * 400 * BIT_NS);
		$display("Watchdog expired before all tests finished");
		$display("Some tests failed");
		$finish;
	end

	task automatic read_trace(output bit ok);
		int         fd;
		int         cnt;
		string      line;
		string      nm;
		int         op;
		logic [7:0] f [18];
		ok = 1'b1;
		fd = $fopen("imu_trace.txt", "r");
		if (fd == 0) begin
			ok = 1'b0;
			return;
		end
		while ($fgets(line, fd) > 0) begin
			if (line.len() < 2 || line[0] == "#")
				continue;
			cnt = $sscanf(line, "%s %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				nm, op, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
				f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
			if (cnt != 20 || n_tests >= MAX_TESTS)
				ok = 1'b0;
			else begin
				t_name[n_tests] = nm;
				t_op[n_tests]   = op;
				t_dev[n_tests]  = f[0];
				t_reg[n_tests]  = f[1];
				t_data[n_tests] = f[2];
				for (int i = 0; i < 14; i++)
					t_pre[n_tests][i] = f[3+i];
				t_exp[n_tests]  = f[17];
				n_tests++;
			end
		end
		$fclose(fd);
	endtask

	task automatic next_cycle();
		@(posedge i2c_clk);
		#1;
	endtask

	task automatic check_val(input string name, input string what,
			input logic [111:0] exp, input logic [111:0] got);
		assert (exp == got) else begin
			$display("Error %s %s: expected %h, actual %h", name, what, exp, got);
			test_err++;
		end
	endtask

	task automatic send_cmd(input host_op_e op, input logic [7:0] dev,
			input logic [7:0] rg, input logic [7:0] d);
		i_cmd_valid = 1'b1;
		i_cmd = '{op: op, dev_addr: dev[6:0], reg_addr: rg, wdata: d};
		while (!o_cmd_ready)
			next_cycle();
		next_cycle();  // accepted on this edge
		i_cmd_valid = 1'b0;
	endtask

	task automatic wait_finish();
		while (!o_status.finish)
			next_cycle();
	endtask

	task automatic pulse_latch();
		i_latch_trigger = 1'b1;
		next_cycle();
		i_latch_trigger = 1'b0;
	endtask

	// drdy edge, then wait for the burst result
	task automatic run_burst();
		i_drdy = 1'b1;
		repeat (4) next_cycle();
		i_drdy = 1'b0;
		while (!DUT.live_update)
			next_cycle();
	endtask

	// little-endian signed pairs in field order
	function automatic imu_sample_t build_sample(input int idx);
		logic signed [15:0] w [7];
		imu_sample_t        s;
		for (int k = 0; k < 7; k++)
			w[k] = {t_pre[idx][2*k+1], t_pre[idx][2*k]};
		s.temp   = w[0];
		s.gyro_x = w[1];
		s.gyro_y = w[2];
		s.gyro_z = w[3];
		s.acc_x  = w[4];
		s.acc_y  = w[5];
		s.acc_z  = w[6];
		return s;
	endfunction

	task automatic run_test(input int idx);
		string       nm;
		imu_sample_t saved;
		logic        exp_nack;
		nm = t_name[idx];
		test_err = 0;
		exp_nack = (t_dev[idx][6:0] != `IMU_DEV_ADDR);
		for (int i = 0; i < 14; i++)
			u_slave.mem[8'(t_reg[idx] + 8'(i))] = t_pre[idx][i];
		saved = o_sample;
		case (t_op[idx])
			0, 1: begin
				send_cmd(t_op[idx] == 0 ? OP_WRITE : OP_READ, t_dev[idx], t_reg[idx],
					t_data[idx]);
				wait_finish();
				check_val(nm, "nack", 112'(exp_nack), 112'(o_status.nack));
				if (t_op[idx] == 0)
					check_val(nm, "slave reg", 112'(t_exp[idx]), 112'(u_slave.mem[t_reg[idx]]));
				else
					check_val(nm, "rd_data", 112'(t_exp[idx]), 112'(o_status.rd_data));
			end
			2: begin
				send_cmd(OP_AUTO_ON, 8'h00, 8'h00, 8'h00);
				wait_finish();
				check_val(nm, "auto_en", 112'(1'b1), 112'(o_status.auto_en));
				run_burst();
				repeat (3) next_cycle();
				check_val(nm, "sample before trigger", saved, o_sample);
				pulse_latch();
				check_val(nm, "sample", build_sample(idx), o_sample);
			end
			3: begin
				send_cmd(OP_AUTO_ON, 8'h00, 8'h00, 8'h00);
				wait_finish();
				// new burst data that never reaches the latch
				for (int i = 0; i < `IMU_BURST_BYTES; i++)
					u_slave.mem[8'(`IMU_REG_OUT_TEMP_L + i)] =
						~u_slave.mem[8'(`IMU_REG_OUT_TEMP_L + i)];
				run_burst();
				send_cmd(OP_AUTO_OFF, 8'h00, 8'h00, 8'h00);
				wait_finish();
				check_val(nm, "auto_en", 112'(1'b0), 112'(o_status.auto_en));
				send_cmd(OP_READ, t_dev[idx], t_reg[idx], 8'h00);
				wait_finish();
				pulse_latch();  // ignored with auto off
				check_val(nm, "rd_data", 112'(t_exp[idx]), 112'(o_status.rd_data));
				check_val(nm, "sample", saved, o_sample);
			end
			default: begin
				send_cmd(OP_WRITE, t_dev[idx], t_reg[idx], t_data[idx]);
				i_cmd_valid = 1'b1;
				i_cmd = '{op: OP_READ, dev_addr: t_dev[idx][6:0], reg_addr: t_reg[idx],
					wdata: 8'h00};
				assert (!o_cmd_ready) else begin
					$display("%s: command ready went high while a transfer was running", nm);
					test_err++;
				end
				check_val(nm, "busy", 112'(1'b1), 112'(o_status.busy));
				send_cmd(OP_READ, t_dev[idx], t_reg[idx], 8'h00);
				wait_finish();
				check_val(nm, "rd_data", 112'(t_exp[idx]), 112'(o_status.rd_data));
				check_val(nm, "slave reg", 112'(t_exp[idx]), 112'(u_slave.mem[t_reg[idx]]));
			end
		endcase
		if (test_err == 0)
			$display("test %s: ok", nm);
		else begin
			$display("test %s: FAILED with %0d errors", nm, test_err);
			n_fail++;
		end
	endtask

	initial begin
		bit ok;
		i_rst_n         = 1'b0;
		i_cmd_valid     = 1'b0;
		i_cmd           = '0;
		i_drdy          = 1'b0;
		i_latch_trigger = 1'b0;
		read_trace(ok);
		if (!ok || n_tests == 0) begin
			$display("Could not read a valid test list from imu_trace.txt");
			$display("Some tests failed");
			$finish;
		end else begin
			repeat (10) @(posedge i2c_clk);
			#1;
			i_rst_n = 1'b1;
			next_cycle();
			for (int i = 0; i < n_tests; i++)
				run_test(i);
			$display("Tests run: %0d, passed: %0d, failed: %0d", n_tests, n_tests - n_fail,
				n_fail);
			if (n_fail == 0)
				$display("All tests passed");
			else
				$display("Some tests failed");
			$finish;
		end
	end

endmodule

`default_nettype wire
